/* tb.f */
+incdir+verification
rtl/camera_pkg.sv
rtl/crop.sv
rtl/knee_compress.sv
rtl/frame_statistics.sv
rtl/camera_stream_top.sv
verification/camera_stream_tb.sv

/* verification/camera_stream_model.svh */
`ifndef CAMERA_STREAM_MODEL_SVH
`define CAMERA_STREAM_MODEL_SVH

// Reference model of the front end, included inside camera_stream_tb.

// three-segment knee curve on one raw value.
function automatic int knee_curve(input int value);
    int low;
    int high;
    low  = int'(camera_pkg::knee_low);
    high = int'(camera_pkg::knee_high);
    if (value < low) return value; // identity segment.
    if (value < high) return int'(camera_pkg::knee_low_out) + (value - low) / 2; // slope 1/2.
    return int'(camera_pkg::knee_high_out) + (value - high) / 8; // slope 1/8.
endfunction

// 32-bit Fibonacci LFSR, taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// expected pixels, line lengths and statistics of the frame held in stim.
task automatic build_expected(input frame_row_t row);
    int r;
    int c;
    int len;
    int value;
    int cut_row;
    bit driven;
    exp_pixels.delete();
    exp_lines.delete();
    exp_sum = 0;
    exp_max = 0;
    cut_row = (row.cut != 0) ? row.height / 2 : row.height; // a cut lands mid row.
    for (r = 0; r < row.height; r++) begin
        len = 0;
        for (c = 0; c < row.width; c++) begin
            driven = (r < cut_row) || (r == cut_row && c < row.width / 2);
            if (driven && c >= row.xs && c < row.xe && r >= row.ys && r < row.ye) begin
                value = knee_curve(stim[r * row.width + c]);
                exp_pixels.push_back(value);
                exp_sum += value;
                if (value > exp_max) exp_max = value;
                len++;
            end
        end
        if (len > 0) exp_lines.push_back(len); // only lines that show up at the output.
    end
    exp_count = exp_pixels.size();
endtask

`endif

/* verification/camera_stream_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module camera_stream_tb;

    localparam int n_frames      = 6;
    localparam int stats_timeout = 200; // clocks allowed for the stats pulse.

    typedef struct packed {
        int width;  // active pixels per line.
        int height; // lines per frame.
        int hblank; // blanking clocks after each line.
        int xs;
        int xe;
        int ys;
        int ye;
        int cut;    // nonzero drops the frame in the middle of a line.
    } frame_row_t;

    logic                               clock_in;
    logic                               rst_n;
    logic [camera_pkg::raw_width-1:0]   raw_pixel;
    logic                               raw_line_valid;
    logic                               raw_frame_valid;
    logic [camera_pkg::coord_width-1:0] x_start;
    logic [camera_pkg::coord_width-1:0] x_end;
    logic [camera_pkg::coord_width-1:0] y_start;
    logic [camera_pkg::coord_width-1:0] y_end;
    logic [camera_pkg::out_width-1:0]   pixel;
    logic                               line_valid;
    logic                               frame_valid;
    logic                               stats_valid;
    logic [camera_pkg::count_width-1:0] pixel_count;
    logic [camera_pkg::sum_width-1:0]   pixel_sum;
    logic [camera_pkg::out_width-1:0]   pixel_max;

    frame_row_t  frame_table [n_frames]; // one row per frame.
    int          stim [0:1023];          // raw pixels of the current frame in raster order.
    logic [31:0] lfsr_state;
    int          exp_pixels [$];
    int          exp_lines [$];
    int          exp_count;
    int          exp_sum;
    int          exp_max;
    int          got_pixels [$];
    int          got_lines [$];
    int          run_len;                // pixels in the output line so far.
    int          stats_pulses;
    int          got_count;
    int          got_sum;
    int          got_max;
    int          error_count;
    int          frames_failed;

    `include "camera_stream_model.svh"

    camera_stream_top camera_stream_top_i (.*);

    initial begin
        clock_in = 1'b0;
        forever #10 clock_in = ~clock_in; // 20 ns period.
    end

    // outputs only move on the rising edge, so read them on the falling one.
    always @(negedge clock_in) begin
        if (line_valid) begin
            got_pixels.push_back(int'(pixel));
            run_len++;
        end else if (run_len > 0) begin
            got_lines.push_back(run_len); // a line just ended.
            run_len = 0;
        end
        if (stats_valid) begin
            stats_pulses++;
            got_count = int'(pixel_count);
            got_sum   = int'(pixel_sum);
            got_max   = int'(pixel_max);
        end
    end

    // knee points and the top code come first in every frame.
    function automatic int edge_value(input int index);
        case (index)
            0: return 0;
            1: return 63;
            2: return 64;
            3: return 65;
            4: return 255;
            5: return 256;
            6: return 257;
            7: return 511;
            8: return 1022;
            default: return 1023;
        endcase
    endfunction

    task automatic make_stimulus(input int count);
        int i;
        int value;
        for (i = 0; i < count; i++) begin
            value = 0;
            repeat (10) begin
                lfsr_state = lfsr_step(lfsr_state);
                value = (value << 1) | int'(lfsr_state[0]); // one bit per step.
            end
            stim[i] = (i < 10) ? edge_value(i) : value;
        end
    endtask

    task automatic drive_frame(input frame_row_t row);
        int r;
        int c;
        bit stopped;
        stopped = 1'b0;
        @(negedge clock_in);
        raw_frame_valid = 1'b1; // one idle clock before the first line.
        for (r = 0; r < row.height; r++) begin
            for (c = 0; c < row.width; c++) begin
                if (!stopped) begin
                    @(negedge clock_in);
                    if (row.cut != 0 && r == row.height / 2 && c == row.width / 2) begin
                        raw_frame_valid = 1'b0; // frame dropped mid line.
                        raw_line_valid  = 1'b0;
                        raw_pixel       = '0;
                        stopped         = 1'b1;
                    end else begin
                        raw_line_valid = 1'b1;
                        raw_pixel      = camera_pkg::raw_width'(stim[r * row.width + c]);
                    end
                end
            end
            if (!stopped) begin
                repeat (row.hblank) begin
                    @(negedge clock_in);
                    raw_line_valid = 1'b0;
                    raw_pixel      = '0;
                end
            end
        end
        if (!stopped) begin
            @(negedge clock_in);
            raw_frame_valid = 1'b0;
        end
    endtask

    task automatic report_mismatch(input string what, input int got, input int expected);
        $display("Fail at %0d ns: %s got %0d expected %0d", $time, what, got, expected);
        error_count++;
    endtask

    task automatic apply_reset;
        @(negedge clock_in);
        rst_n = 1'b0;
        repeat (2) @(negedge clock_in); // two rising edges in reset.
        rst_n = 1'b1;
        if (line_valid !== 1'b0) report_mismatch("line_valid after reset", int'(line_valid), 0);
        if (frame_valid !== 1'b0) report_mismatch("frame_valid after reset", int'(frame_valid), 0);
        if (stats_valid !== 1'b0) report_mismatch("stats_valid after reset", int'(stats_valid), 0);
        if (pixel !== '0) report_mismatch("pixel after reset", int'(pixel), 0);
    endtask

    task automatic wait_for_stats(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < stats_timeout) begin
            @(negedge clock_in);
            cycles++;
            if (stats_pulses > 0) seen = 1'b1;
        end
        repeat (4) @(negedge clock_in); // room for a stray second pulse.
    endtask

    task automatic check_frame;
        int i;
        if (stats_pulses != 1) report_mismatch("stats_valid pulses", stats_pulses, 1);
        if (got_count != exp_count) report_mismatch("pixel_count", got_count, exp_count);
        if (got_sum != exp_sum) report_mismatch("pixel_sum", got_sum, exp_sum);
        if (got_max != exp_max) report_mismatch("pixel_max", got_max, exp_max);
        if (got_lines.size() != exp_lines.size()) begin
            report_mismatch("output lines", got_lines.size(), exp_lines.size());
        end
        for (i = 0; i < got_lines.size() && i < exp_lines.size(); i++) begin
            if (got_lines[i] != exp_lines[i]) begin
                report_mismatch($sformatf("pixels in line %0d", i), got_lines[i], exp_lines[i]);
            end
        end
        if (got_pixels.size() != exp_pixels.size()) begin
            report_mismatch("output pixels", got_pixels.size(), exp_pixels.size());
        end
        for (i = 0; i < got_pixels.size() && i < exp_pixels.size(); i++) begin
            if (got_pixels[i] != exp_pixels[i]) begin
                report_mismatch($sformatf("pixel %0d", i), got_pixels[i], exp_pixels[i]);
            end
        end
    endtask

    initial begin
        frame_row_t row;
        int         f;
        int         errors_before;
        bit         seen;
        bit         timed_out;
        rst_n           = 1'b0;
        raw_pixel       = '0;
        raw_line_valid  = 1'b0;
        raw_frame_valid = 1'b0;
        x_start         = '0;
        x_end           = '0;
        y_start         = '0;
        y_end           = '0;
        lfsr_state      = 32'hd6c;
        error_count     = 0;
        frames_failed   = 0;
        timed_out       = 1'b0;
        // width, height, hblank, x_start, x_end, y_start, y_end, cut.
        frame_table[0] = {32'd16, 32'd8, 32'd3, 32'd0, 32'd16, 32'd0, 32'd8, 32'd0};
        frame_table[1] = {32'd20, 32'd10, 32'd4, 32'd3, 32'd11, 32'd2, 32'd7, 32'd0};
        frame_table[2] = {32'd12, 32'd6, 32'd2, 32'd5, 32'd30, 32'd4, 32'd20, 32'd0};
        frame_table[3] = {32'd16, 32'd8, 32'd3, 32'd6, 32'd6, 32'd2, 32'd5, 32'd0};
        frame_table[4] = {32'd16, 32'd8, 32'd2, 32'd2, 32'd14, 32'd1, 32'd7, 32'd1};
        frame_table[5] = {32'd16, 32'd8, 32'd3, 32'd0, 32'd10, 32'd0, 32'd3, 32'd0};
        apply_reset();
        for (f = 0; f < n_frames && !timed_out; f++) begin
            row = frame_table[f];
            @(negedge clock_in);
            x_start = camera_pkg::coord_width'(row.xs); // window is set in the gap.
            x_end   = camera_pkg::coord_width'(row.xe);
            y_start = camera_pkg::coord_width'(row.ys);
            y_end   = camera_pkg::coord_width'(row.ye);
            got_pixels.delete();
            got_lines.delete();
            stats_pulses = 0;
            make_stimulus(row.width * row.height);
            build_expected(row);
            errors_before = error_count;
            drive_frame(row);
            wait_for_stats(seen);
            if (!seen) begin
                $display("timeout: no stats_valid pulse after frame %0d", f);
                timed_out = 1'b1;
            end else begin
                check_frame();
                if (error_count != errors_before) frames_failed++;
                $display("frame %0d: %0dx%0d, window x %0d..%0d y %0d..%0d, %0d pixels, %s",
                         f, row.width, row.height, row.xs, row.xe, row.ys, row.ye,
                         got_pixels.size(), (error_count == errors_before) ? "ok" : "wrong");
            end
        end
        $display("frames run %0d, frames failed %0d, errors %0d", f, frames_failed, error_count);
        if (timed_out || error_count != 0) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/camera_stream_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Sensor stream front end: crop window, knee compression, frame statistics.
module camera_stream_top (
    input  logic                               clock_in,
    input  logic                               rst_n,
    input  logic [camera_pkg::raw_width-1:0]   raw_pixel,
    input  logic                               raw_line_valid,
    input  logic                               raw_frame_valid,
    input  logic [camera_pkg::coord_width-1:0] x_start,
    input  logic [camera_pkg::coord_width-1:0] x_end,
    input  logic [camera_pkg::coord_width-1:0] y_start,
    input  logic [camera_pkg::coord_width-1:0] y_end,
    output logic [camera_pkg::out_width-1:0]   pixel,
    output logic                               line_valid,
    output logic                               frame_valid,
    output logic                               stats_valid,
    output logic [camera_pkg::count_width-1:0] pixel_count,
    output logic [camera_pkg::sum_width-1:0]   pixel_sum,
    output logic [camera_pkg::out_width-1:0]   pixel_max
);

    logic [camera_pkg::raw_width-1:0] crop_pixel;       // windowed raw pixel.
    logic                             crop_line_valid;  // windowed line level.
    logic                             crop_frame_valid; // frame level, one clock late.

    // first stage, one clock.
    crop crop_i (
        .clock_in         (clock_in),
        .rst_n            (rst_n),
        .raw_pixel        (raw_pixel),
        .raw_line_valid   (raw_line_valid),
        .raw_frame_valid  (raw_frame_valid),
        .x_start          (x_start),
        .x_end            (x_end),
        .y_start          (y_start),
        .y_end            (y_end),
        .crop_pixel       (crop_pixel),
        .crop_line_valid  (crop_line_valid),
        .crop_frame_valid (crop_frame_valid)
    );

    // second stage, one clock, drives the outputs.
    knee_compress knee_compress_i (
        .clock_in         (clock_in),
        .rst_n            (rst_n),
        .crop_pixel       (crop_pixel),
        .crop_line_valid  (crop_line_valid),
        .crop_frame_valid (crop_frame_valid),
        .pixel            (pixel),
        .line_valid       (line_valid),
        .frame_valid      (frame_valid)
    );

    // statistics see exactly what leaves the block.
    frame_statistics frame_statistics_i (
        .clock_in    (clock_in),
        .rst_n       (rst_n),
        .pixel       (pixel),
        .line_valid  (line_valid),
        .frame_valid (frame_valid),
        .stats_valid (stats_valid),
        .pixel_count (pixel_count),
        .pixel_sum   (pixel_sum),
        .pixel_max   (pixel_max)
    );

endmodule

`default_nettype wire

/* rtl/frame_statistics.sv */
`timescale 1ns/1ps
`default_nettype none

// Per-frame pixel count, sum and maximum of the compressed stream.
module frame_statistics (
    input  logic                               clock_in,
    input  logic                               rst_n,
    input  logic [camera_pkg::out_width-1:0]   pixel,
    input  logic                               line_valid,
    input  logic                               frame_valid,
    output logic                               stats_valid,
    output logic [camera_pkg::count_width-1:0] pixel_count,
    output logic [camera_pkg::sum_width-1:0]   pixel_sum,
    output logic [camera_pkg::out_width-1:0]   pixel_max
);

    logic [camera_pkg::count_width-1:0] run_count; // pixels so far in this frame.
    logic [camera_pkg::sum_width-1:0]   run_sum;   // sum so far in this frame.
    logic [camera_pkg::out_width-1:0]   run_max;   // largest pixel so far.
    logic [camera_pkg::sum_width-1:0]   pixel_wide; // pixel zero-extended for the sum.
    logic                               frame_valid_q; // frame_valid one clock ago.
    logic                               frame_end;     // first low cycle after a frame.
    logic                               new_max;       // current pixel beats run_max.

    assign pixel_wide = {{(camera_pkg::sum_width - camera_pkg::out_width){1'b0}}, pixel};
    assign frame_end  = frame_valid_q && !frame_valid;
    assign new_max    = pixel > run_max;

    // running accumulators.
    always_ff @(posedge clock_in) begin
        if (!rst_n) begin
            run_count <= '0;
            run_sum   <= '0;
            run_max   <= '0;
        end else if (!frame_valid) begin
            // held at zero in the gap so a new frame starts clean.
            run_count <= '0;
            run_sum   <= '0;
            run_max   <= '0;
        end else if (line_valid) begin
            run_count <= run_count + camera_pkg::count_width'(1); // one more pixel.
            run_sum   <= run_sum + pixel_wide;
            if (new_max) begin
                run_max <= pixel;
            end
        end
    end

    // frame end detection and result capture.
    always_ff @(posedge clock_in) begin
        if (!rst_n) begin
            frame_valid_q <= 1'b0;
            stats_valid   <= 1'b0;
            pixel_count   <= '0;
            pixel_sum     <= '0;
            pixel_max     <= '0;
        end else begin
            frame_valid_q <= frame_valid;
            stats_valid   <= frame_end; // single clock pulse.

            // accumulators still hold the whole frame in the first low cycle.
            if (frame_end) begin
                pixel_count <= run_count;
                pixel_sum   <= run_sum;
                pixel_max   <= run_max;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/knee_compress.sv */
`timescale 1ns/1ps
`default_nettype none

// Compresses 10-bit pixels to 8 bits with a fixed three-segment knee curve.
module knee_compress (
    input  logic                             clock_in,
    input  logic                             rst_n,
    input  logic [camera_pkg::raw_width-1:0] crop_pixel,
    input  logic                             crop_line_valid,
    input  logic                             crop_frame_valid,
    output logic [camera_pkg::out_width-1:0] pixel,
    output logic                             line_valid,
    output logic                             frame_valid
);

    logic [camera_pkg::raw_width-1:0] excess_low;    // input above knee_low.
    logic [camera_pkg::raw_width-1:0] excess_high;   // input above knee_high.
    logic [camera_pkg::raw_width-1:0] half_excess;   // mid segment slope of 1/2.
    logic [camera_pkg::raw_width-1:0] eighth_excess; // top segment slope of 1/8.
    logic [camera_pkg::out_width-1:0] low_segment;   // identity part.
    logic [camera_pkg::out_width-1:0] mid_segment;   // between the knees.
    logic [camera_pkg::out_width-1:0] top_segment;   // above the upper knee.
    logic [camera_pkg::out_width-1:0] curve_value;   // selected segment.
    logic                             below_low;     // input under knee_low.
    logic                             below_high;    // input under knee_high.

    // segment select.
    assign below_low  = crop_pixel < camera_pkg::knee_low;
    assign below_high = crop_pixel < camera_pkg::knee_high;

    // offsets only matter on the segment that uses them, wrap elsewhere is harmless.
    assign excess_low  = crop_pixel - camera_pkg::knee_low;
    assign excess_high = crop_pixel - camera_pkg::knee_high;

    assign half_excess   = excess_low >> 1;  // at most 95 between the knees.
    assign eighth_excess = excess_high >> 3; // at most 95 up to 1023.

    assign low_segment = crop_pixel[camera_pkg::out_width-1:0]; // fits, input below 64.
    assign mid_segment = camera_pkg::knee_low_out + half_excess[camera_pkg::out_width-1:0];
    assign top_segment = camera_pkg::knee_high_out
                       + eighth_excess[camera_pkg::out_width-1:0]; // tops out at 255.

    always_comb begin
        if (below_low) begin
            curve_value = low_segment;
        end else if (below_high) begin
            curve_value = mid_segment;
        end else begin
            curve_value = top_segment;
        end
    end

    always_ff @(posedge clock_in) begin
        if (!rst_n) begin
            pixel       <= '0;
            line_valid  <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            if (crop_line_valid) begin
                pixel <= curve_value; // compressed pixel.
            end else begin
                pixel <= '0; // blanking reads as zero.
            end
            line_valid  <= crop_line_valid;  // same one clock delay as the pixel.
            frame_valid <= crop_frame_valid;
        end
    end

endmodule

`default_nettype wire

/* rtl/crop.sv */
`timescale 1ns/1ps
`default_nettype none

// Keeps only the pixels of a frame that fall inside a rectangular window.
module crop (
    input  logic                               clock_in,
    input  logic                               rst_n,
    input  logic [camera_pkg::raw_width-1:0]   raw_pixel,
    input  logic                               raw_line_valid,
    input  logic                               raw_frame_valid,
    input  logic [camera_pkg::coord_width-1:0] x_start,
    input  logic [camera_pkg::coord_width-1:0] x_end,
    input  logic [camera_pkg::coord_width-1:0] y_start,
    input  logic [camera_pkg::coord_width-1:0] y_end,
    output logic [camera_pkg::raw_width-1:0]   crop_pixel,
    output logic                               crop_line_valid,
    output logic                               crop_frame_valid
);

    logic [camera_pkg::coord_width-1:0] x_count;  // pixels seen so far in this line.
    logic [camera_pkg::coord_width-1:0] y_count;  // lines completed in this frame.
    logic                               line_valid_q; // line_valid one clock ago.
    logic                               line_end;     // falling edge of line_valid.
    logic                               x_inside;     // column lies in the window.
    logic                               y_inside;     // row lies in the window.
    logic                               keep;         // current pixel is kept.

    assign line_end = line_valid_q && !raw_line_valid; // last pixel went by last clock.

    // a start that is not below its end can never satisfy both compares.
    assign x_inside = (x_count >= x_start) && (x_count < x_end);
    assign y_inside = (y_count >= y_start) && (y_count < y_end);
    assign keep     = raw_line_valid && x_inside && y_inside;

    always_ff @(posedge clock_in) begin
        if (!rst_n || !raw_frame_valid) begin
            // the frame gap behaves like reset.
            x_count          <= '0;
            y_count          <= '0;
            line_valid_q     <= 1'b0;
            crop_pixel       <= '0;
            crop_line_valid  <= 1'b0;
            crop_frame_valid <= 1'b0;
        end else begin
            line_valid_q <= raw_line_valid; // remembered for line end detection.

            if (raw_line_valid) begin
                x_count <= x_count + camera_pkg::coord_width'(1); // next column.
            end else begin
                x_count <= '0; // horizontal blanking restarts the column.
            end

            if (line_end) begin
                y_count <= y_count + camera_pkg::coord_width'(1); // one more line done.
            end

            if (keep) begin
                crop_pixel      <= raw_pixel; // pass the pixel through.
                crop_line_valid <= 1'b1;
            end else begin
                crop_pixel      <= '0; // dropped pixels read as zero.
                crop_line_valid <= 1'b0;
            end

            crop_frame_valid <= raw_frame_valid; // frame level tracks the pixel delay.
        end
    end

endmodule

`default_nettype wire

/* rtl/camera_pkg.sv */
`default_nettype none

// Shared widths and knee curve constants of the raw camera front end.
package camera_pkg;

    // datapath widths.
    localparam int raw_width   = 10; // bits of one sensor pixel.
    localparam int coord_width = 10; // column and row counters, up to 1024 x 1024.
    localparam int out_width   = 8;  // bits of one compressed pixel.
    localparam int count_width = 21; // holds 1024 * 1024 pixels.
    localparam int sum_width   = 29; // holds 1024 * 1024 * 255.

    // knee points on the input axis.
    localparam logic [raw_width-1:0] knee_low  = raw_width'(64);  // identity below this.
    localparam logic [raw_width-1:0] knee_high = raw_width'(256); // third segment from here.

    // curve output at each knee point.
    localparam logic [out_width-1:0] knee_low_out  = out_width'(64);  // output at knee_low.
    localparam logic [out_width-1:0] knee_high_out = out_width'(160); // output at knee_high.

    // The segments are
    //   in <  knee_low            : out = in
    //   knee_low <= in < knee_high : out = knee_low_out  + (in - knee_low)  / 2
    //   in >= knee_high           : out = knee_high_out + (in - knee_high) / 8
    // so 1023 lands exactly on 255.

endpackage

`default_nettype wire
